// File: vlog.f
+incdir+src
src/mem_hier_pkg.sv
src/direct_mapped_cache.sv
src/unified_mem.sv
src/cache_controller.sv
src/memory_hierarchy.sv
tests/memory_hierarchy_props.sv
tests/memory_hierarchy_tb.sv

// File: Makefile
# Verilator build and run of the memory hierarchy testbench.

VERILATOR ?= verilator
TOP       ?= memory_hierarchy_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard src/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^test passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/memory_hierarchy_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_hier_params.svh"

module memory_hierarchy_tb;

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DLY    = 2;
	localparam int RESET_CYCLES = 5;
	localparam int ADDR_W       = `MH_TAG_W + `MH_INDEX_W + 2;
	localparam int CLEAN_MISS   = `MH_MEM_LATENCY + 2; // Stall of a clean miss.
	localparam int STALL_LIMIT  = 2 * CLEAN_MISS;
	// Some 30 accesses of at most STALL_LIMIT + 2 cycles leave a wide margin.
	localparam int TIMEOUT_CYCLES = 3000;

	typedef enum {IFETCH, DREAD, DWRITE} access_kind_e;

	logic                  clk;
	logic                  i_rst;
	logic                  i_i_acc;
	logic                  i_d_rd_acc;
	logic                  i_d_wr_acc;
	logic [ADDR_W-1:0]     i_i_addr;
	logic [ADDR_W-1:0]     i_d_addr;
	logic [`MH_WORD_W-1:0] i_d_wrt_data;
	logic                  o_stall;
	logic [`MH_WORD_W-1:0] o_instr;
	logic [`MH_WORD_W-1:0] o_data;

	logic [31:0]           lfsr;
	logic [`MH_WORD_W-1:0] shadow [1 << ADDR_W] = '{default: '0}; // Processor view of memory.
	int                    cycles = 0;

	memory_hierarchy UUT (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_i_acc      (i_i_acc),
		.i_d_rd_acc   (i_d_rd_acc),
		.i_d_wr_acc   (i_d_wr_acc),
		.i_i_addr     (i_i_addr),
		.i_d_addr     (i_d_addr),
		.i_d_wrt_data (i_d_wrt_data),
		.o_stall      (o_stall),
		.o_instr      (o_instr),
		.o_data       (o_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run("Timeout, the tests did not finish within the cycle limit.");
		end
	end

	// Protocol assertions bound into the controller.
	always @(negedge clk) begin
		if (UUT.controller.props.failures != 0) begin
			abort_run("A protocol assertion on the controller failed.");
		end
	end

	function automatic logic [ADDR_W-1:0] make_addr(
		input logic [`MH_TAG_W-1:0]   tag,
		input logic [`MH_INDEX_W-1:0] index,
		input logic [1:0]             off
	);
		return {tag, index, off};
	endfunction

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_word(output logic [`MH_WORD_W-1:0] w);
		w = '0;
		for (int b = 0; b < `MH_WORD_W; b++) begin
			lfsr = lfsr_next(lfsr);
			w    = {w[`MH_WORD_W-2:0], lfsr[0]}; // One step per bit.
		end
	endtask

	task automatic drive_idle();
		i_i_acc    = 1'b0;
		i_d_rd_acc = 1'b0;
		i_d_wr_acc = 1'b0;
	endtask

	task automatic check_word(input string name, input logic [`MH_WORD_W-1:0] got,
			input logic [`MH_WORD_W-1:0] exp);
		assert (got === exp) else begin
			abort_run($sformatf("CHECK FAILED: %s = %h, expected %h", name, got, exp));
		end
	endtask

	// Counts stalled cycles at mid-cycle.
	task automatic wait_unstalled(output int stalls);
		stalls = 0;
		@(negedge clk);
		while (o_stall) begin
			stalls++;
			@(negedge clk);
		end
		assert (stalls <= STALL_LIMIT) else begin
			abort_run($sformatf("Stall lasted %0d cycles, the limit is %0d.", stalls, STALL_LIMIT));
		end
	endtask

	task automatic access(input access_kind_e kind, input logic [ADDR_W-1:0] addr,
			input logic [`MH_WORD_W-1:0] data, input bit exp_hit, output int stalls);
		@(posedge clk);
		#DRIVE_DLY;
		case (kind)
			IFETCH: begin
				i_i_acc  = 1'b1;
				i_i_addr = addr;
			end
			DREAD: begin
				i_d_rd_acc = 1'b1;
				i_d_addr   = addr;
			end
			DWRITE: begin
				i_d_wr_acc   = 1'b1;
				i_d_addr     = addr;
				i_d_wrt_data = data;
			end
		endcase
		wait_unstalled(stalls);
		if (exp_hit) begin
			assert (stalls == 0) else begin
				abort_run($sformatf("Access to %h should hit but stalled.", addr));
			end
		end else begin
			assert (stalls > 0) else begin
				abort_run($sformatf("Access to %h should miss but did not stall.", addr));
			end
		end
		case (kind)
			IFETCH: check_word("o_instr", o_instr, shadow[addr]);
			DREAD:  check_word("o_data", o_data, shadow[addr]);
			DWRITE: shadow[addr] = data; // Commits at the coming edge.
		endcase
		@(posedge clk);
		#DRIVE_DLY;
		drive_idle();
	endtask

	task automatic fetch_both(input logic [ADDR_W-1:0] iaddr, input logic [ADDR_W-1:0] daddr);
		int stalls;
		@(posedge clk);
		#DRIVE_DLY;
		i_i_acc    = 1'b1;
		i_i_addr   = iaddr;
		i_d_rd_acc = 1'b1;
		i_d_addr   = daddr;
		wait_unstalled(stalls);
		assert (stalls > 0) else begin
			abort_run("Misses on both ports did not stall.");
		end
		check_word("o_instr", o_instr, shadow[iaddr]);
		check_word("o_data", o_data, shadow[daddr]);
		@(posedge clk);
		#DRIVE_DLY;
		drive_idle();
	endtask

	// Requests held during reset must not stall.
	task automatic test_reset();
		i_rst      = 1'b1;
		i_i_acc    = 1'b1;
		i_d_rd_acc = 1'b1;
		for (int n = 0; n < RESET_CYCLES; n++) begin
			@(posedge clk);
			#DRIVE_DLY;
			check_word("o_instr", o_instr, `MH_RESET_INSTR);
			check_word("o_data", o_data, `MH_RESET_DATA);
			assert (o_stall === 1'b0) else begin
				abort_run($sformatf("CHECK FAILED: o_stall = %h, expected 0", o_stall));
			end
		end
		i_rst = 1'b0;
		drive_idle();
	endtask

	task automatic test_first_read();
		int stalls;
		access(DREAD, make_addr(8'h01, 6'd1, 2'd0), '0, 1'b0, stalls);
		assert (stalls == CLEAN_MISS) else begin
			abort_run($sformatf("Clean miss stalled %0d cycles, expected %0d.", stalls, CLEAN_MISS));
		end
		access(DREAD, make_addr(8'h01, 6'd1, 2'd3), '0, 1'b1, stalls);
	endtask

	task automatic test_line_words();
		logic [`MH_WORD_W-1:0] w;
		int                    stalls;
		for (int off = 0; off < `MH_LINE_WORDS; off++) begin
			random_word(w);
			access(DWRITE, make_addr(8'h01, 6'd1, 2'(off)), w, 1'b1, stalls);
		end
		for (int off = 0; off < `MH_LINE_WORDS; off++) begin
			access(DREAD, make_addr(8'h01, 6'd1, 2'(off)), '0, 1'b1, stalls);
		end
	endtask

	// Same index with another tag forces the writeback.
	task automatic test_dirty_evict();
		logic [`MH_WORD_W-1:0] w;
		int                    stalls;
		for (int off = 0; off < `MH_LINE_WORDS; off++) begin
			random_word(w);
			access(DWRITE, make_addr(8'h02, 6'd5, 2'(off)), w, off != 0, stalls);
		end
		access(DREAD, make_addr(8'h03, 6'd5, 2'd2), '0, 1'b0, stalls);
		for (int off = 0; off < `MH_LINE_WORDS; off++) begin
			access(DREAD, make_addr(8'h02, 6'd5, 2'(off)), '0, off != 0, stalls);
		end
	endtask

	task automatic test_unified();
		logic [`MH_WORD_W-1:0] w;
		int                    stalls;
		random_word(w);
		access(DWRITE, make_addr(8'h10, 6'd9, 2'd3), w, 1'b0, stalls);
		access(DREAD, make_addr(8'h11, 6'd9, 2'd0), '0, 1'b0, stalls); // Evicts the dirty line.
		access(IFETCH, make_addr(8'h10, 6'd9, 2'd3), '0, 1'b0, stalls);
		access(IFETCH, make_addr(8'h10, 6'd9, 2'd3), '0, 1'b1, stalls);
	endtask

	// Both lines were written back earlier so the data side misses clean.
	task automatic test_dual_miss();
		fetch_both(make_addr(8'h02, 6'd5, 2'd1), make_addr(8'h10, 6'd9, 2'd3));
	endtask

	initial begin
		lfsr         = 32'h0c7e_db0a;
		i_rst        = 1'b1;
		i_i_addr     = '0;
		i_d_addr     = '0;
		i_d_wrt_data = '0;
		drive_idle();
		test_reset();
		test_first_read();
		test_line_words();
		test_dirty_evict();
		test_unified();
		test_dual_miss();
		if (UUT.controller.props.failures == 0) begin
			$display("test passed");
			$finish;
		end else begin
			abort_run("A protocol assertion on the controller failed.");
		end
	end

endmodule

`default_nettype wire

// File: tests/memory_hierarchy_props.sv
`timescale 1ns/1ps
`default_nettype none

module memory_hierarchy_props (
	input wire logic                      clk,
	input wire logic                      i_rst,
	input wire mem_hier_pkg::ctrl_state_e i_state,
	input wire mem_hier_pkg::mem_req_t    i_m_req,
	input wire logic                      i_m_rdy,
	input wire logic                      i_i_we,
	input wire logic                      i_d_we
);

	int failures = 0; // Count of failed assertions.

	request_held: assert property (@(posedge clk) disable iff (i_rst)
		(i_m_req.re || i_m_req.we) && !i_m_rdy |=> $stable(i_m_req))
		else begin
			failures++;
			$error("Memory request changed before the ready pulse.");
		end

	ready_with_request: assert property (@(posedge clk) disable iff (i_rst)
		i_m_rdy |-> (i_m_req.re || i_m_req.we))
		else begin
			failures++;
			$error("Ready pulse without a memory request.");
		end

	writeback_no_cache_write: assert property (@(posedge clk) disable iff (i_rst)
		(i_state == mem_hier_pkg::D_WRITEBACK) |-> !(i_i_we || i_d_we))
		else begin
			failures++;
			$error("Cache written during writeback.");
		end

endmodule

bind cache_controller memory_hierarchy_props props (
	.clk     (clk),
	.i_rst   (i_rst),
	.i_state (state_q),
	.i_m_req (o_m_req),
	.i_m_rdy (i_m_rdy),
	.i_i_we  (o_i_wr.we),
	.i_d_we  (o_d_wr.we)
);

`default_nettype wire

// File: src/memory_hierarchy.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_hier_params.svh"

module memory_hierarchy (
	input  wire logic                                 clk,
	input  wire logic                                 i_rst,
	input  wire logic                                 i_i_acc,
	input  wire logic                                 i_d_rd_acc,
	input  wire logic                                 i_d_wr_acc,
	input  wire logic [`MH_TAG_W+`MH_INDEX_W+1:0]     i_i_addr,
	input  wire logic [`MH_TAG_W+`MH_INDEX_W+1:0]     i_d_addr,
	input  wire logic [`MH_WORD_W-1:0]                i_d_wrt_data,
	output logic                                      o_stall,
	output logic [`MH_WORD_W-1:0]                     o_instr,
	output logic [`MH_WORD_W-1:0]                     o_data
);

	logic d_acc;

	logic                    i_hit;
	logic                    d_hit;
	logic                    d_dirty;
	logic [`MH_TAG_W-1:0]    d_tag;
	mem_hier_pkg::line_t     i_line;
	mem_hier_pkg::line_t     d_line;
	mem_hier_pkg::line_t     m_line;
	logic                    m_rdy;

	mem_hier_pkg::cache_wr_t i_wr;
	mem_hier_pkg::cache_wr_t d_wr;
	mem_hier_pkg::mem_req_t  m_req;

	assign d_acc = i_d_rd_acc | i_d_wr_acc; // Reads and writes share the lookup.

	// Read only, so dirty and tag go nowhere.
	direct_mapped_cache icache (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_addr  (i_i_addr[`MH_TAG_W+`MH_INDEX_W+1:2]),
		.i_acc   (i_i_acc),
		.i_wr    (i_wr),
		.o_hit   (i_hit),
		.o_dirty (),
		.o_tag   (),
		.o_line  (i_line)
	);

	direct_mapped_cache dcache (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_addr  (i_d_addr[`MH_TAG_W+`MH_INDEX_W+1:2]),
		.i_acc   (d_acc),
		.i_wr    (d_wr),
		.o_hit   (d_hit),
		.o_dirty (d_dirty),
		.o_tag   (d_tag),
		.o_line  (d_line)
	);

	unified_mem main_mem (
		.clk    (clk),
		.i_rst  (i_rst),
		.i_req  (m_req),
		.o_line (m_line),
		.o_rdy  (m_rdy)
	);

	cache_controller controller (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_i_acc    (i_i_acc),
		.i_i_addr   (i_i_addr),
		.i_d_acc    (d_acc),
		.i_d_wr     (i_d_wr_acc),
		.i_d_addr   (i_d_addr),
		.i_wrt_data (i_d_wrt_data),
		.i_i_hit    (i_hit),
		.i_d_hit    (d_hit),
		.i_d_dirty  (d_dirty),
		.i_d_tag    (d_tag),
		.i_d_line   (d_line),
		.i_m_line   (m_line),
		.i_m_rdy    (m_rdy),
		.o_i_wr     (i_wr),
		.o_d_wr     (d_wr),
		.o_m_req    (m_req),
		.o_stall    (o_stall)
	);

	// Word select by offset, fixed words in reset.
	assign o_instr = i_rst ? `MH_RESET_INSTR : i_line[i_i_addr[1:0]];
	assign o_data  = i_rst ? `MH_RESET_DATA : d_line[i_d_addr[1:0]];

endmodule

`default_nettype wire

// File: src/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_hier_params.svh"

module cache_controller (
	input  wire logic                                 clk,
	input  wire logic                                 i_rst,
	input  wire logic                                 i_i_acc,
	input  wire logic [`MH_TAG_W+`MH_INDEX_W+1:0]     i_i_addr,
	input  wire logic                                 i_d_acc,
	input  wire logic                                 i_d_wr,
	input  wire logic [`MH_TAG_W+`MH_INDEX_W+1:0]     i_d_addr,
	input  wire logic [`MH_WORD_W-1:0]                i_wrt_data,
	input  wire logic                                 i_i_hit,
	input  wire logic                                 i_d_hit,
	input  wire logic                                 i_d_dirty,
	input  wire logic [`MH_TAG_W-1:0]                 i_d_tag,
	input  wire mem_hier_pkg::line_t                  i_d_line,
	input  wire mem_hier_pkg::line_t                  i_m_line,
	input  wire logic                                 i_m_rdy,
	output mem_hier_pkg::cache_wr_t                   o_i_wr,
	output mem_hier_pkg::cache_wr_t                   o_d_wr,
	output mem_hier_pkg::mem_req_t                    o_m_req,
	output logic                                      o_stall
);

	localparam int OFF_W   = $clog2(`MH_LINE_WORDS);
	localparam int LADDR_W = `MH_TAG_W + `MH_INDEX_W;

	mem_hier_pkg::ctrl_state_e state_q;
	mem_hier_pkg::ctrl_state_e state_d;

	logic i_miss;
	logic d_miss;

	mem_hier_pkg::line_t hit_merged;
	mem_hier_pkg::line_t fill_merged;

	// Replace one word of a line.
	function automatic mem_hier_pkg::line_t merge_word(
		input mem_hier_pkg::line_t line,
		input logic [OFF_W-1:0]    off,
		input logic [`MH_WORD_W-1:0] word
	);
		mem_hier_pkg::line_t merged;
		merged      = line;
		merged[off] = word;
		return merged;
	endfunction

	assign i_miss = i_i_acc & ~i_i_hit;
	assign d_miss = i_d_acc & ~i_d_hit;

	assign hit_merged  = merge_word(i_d_line, i_d_addr[OFF_W-1:0], i_wrt_data);
	assign fill_merged = merge_word(i_m_line, i_d_addr[OFF_W-1:0], i_wrt_data);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state_q <= mem_hier_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Data misses go first.
	always_comb begin
		state_d = state_q;
		case (state_q)
			mem_hier_pkg::IDLE: begin
				if (d_miss) begin
					state_d = i_d_dirty ? mem_hier_pkg::D_WRITEBACK : mem_hier_pkg::D_FILL;
				end else if (i_miss) begin
					state_d = mem_hier_pkg::I_FILL;
				end
			end
			mem_hier_pkg::D_WRITEBACK: begin
				if (i_m_rdy) state_d = mem_hier_pkg::D_FILL;
			end
			mem_hier_pkg::D_FILL: begin
				// Chain straight into a pending instruction miss.
				if (i_m_rdy) state_d = i_miss ? mem_hier_pkg::I_FILL : mem_hier_pkg::IDLE;
			end
			mem_hier_pkg::I_FILL: begin
				if (i_m_rdy) state_d = mem_hier_pkg::IDLE;
			end
			default: state_d = mem_hier_pkg::IDLE;
		endcase
	end

	// Held for the whole phase, addresses come from the held access.
	always_comb begin
		o_m_req = '0;
		case (state_q)
			mem_hier_pkg::D_WRITEBACK: begin
				o_m_req.we    = 1'b1;
				o_m_req.addr  = {i_d_tag, i_d_addr[`MH_INDEX_W+OFF_W-1:OFF_W]}; // Victim line.
				o_m_req.wdata = i_d_line;
			end
			mem_hier_pkg::D_FILL: begin
				o_m_req.re   = 1'b1;
				o_m_req.addr = i_d_addr[LADDR_W+OFF_W-1:OFF_W];
			end
			mem_hier_pkg::I_FILL: begin
				o_m_req.re   = 1'b1;
				o_m_req.addr = i_i_addr[LADDR_W+OFF_W-1:OFF_W];
			end
			default: o_m_req = '0;
		endcase
	end

	always_comb begin
		o_d_wr = '0;
		if (state_q == mem_hier_pkg::D_FILL && i_m_rdy) begin
			o_d_wr.we    = 1'b1;
			o_d_wr.dirty = i_d_wr; // Write miss stores dirty.
			o_d_wr.line  = i_d_wr ? fill_merged : i_m_line;
		end else if (i_d_wr && i_d_hit) begin
			o_d_wr.we    = 1'b1;
			o_d_wr.dirty = 1'b1;
			o_d_wr.line  = hit_merged;
		end
	end

	always_comb begin
		o_i_wr       = '0;
		o_i_wr.we    = (state_q == mem_hier_pkg::I_FILL) && i_m_rdy;
		o_i_wr.line  = i_m_line; // Always clean.
	end

	assign o_stall = ~i_rst & (i_miss | d_miss | (state_q != mem_hier_pkg::IDLE));

endmodule

`default_nettype wire

// File: src/unified_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_hier_params.svh"

module unified_mem (
	input  wire logic                    clk,
	input  wire logic                    i_rst,
	input  wire mem_hier_pkg::mem_req_t  i_req,
	output mem_hier_pkg::line_t          o_line,
	output logic                         o_rdy
);

	localparam int LINES = 1 << (`MH_TAG_W + `MH_INDEX_W);
	localparam int CNT_W = $clog2(`MH_MEM_LATENCY + 1);

	mem_hier_pkg::line_t mem [LINES];

	logic [CNT_W-1:0] cnt_q; // Zero when idle.
	logic             last;

	initial begin
		for (int i = 0; i < LINES; i++) begin
			mem[i] = '0;
		end
	end

	// Final busy cycle before the ready pulse.
	assign last = (cnt_q == CNT_W'(`MH_MEM_LATENCY - 1)) && !o_rdy;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			cnt_q <= '0;
			o_rdy <= 1'b0;
		end else if (o_rdy) begin
			cnt_q <= '0; // Back to idle after the pulse.
			o_rdy <= 1'b0;
		end else if (cnt_q == '0) begin
			if (i_req.re || i_req.we) begin
				cnt_q <= CNT_W'(1);
			end
		end else begin
			cnt_q <= cnt_q + CNT_W'(1);
			o_rdy <= last;
		end
	end

	// Read line and write commit land on the edge that raises o_rdy.
	always_ff @(posedge clk) begin
		if (last) begin
			if (i_req.re) o_line <= mem[i_req.addr];
			if (i_req.we) mem[i_req.addr] <= i_req.wdata;
		end
	end

endmodule

`default_nettype wire

// File: src/direct_mapped_cache.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_hier_params.svh"

module direct_mapped_cache (
	input  wire logic                                 clk,
	input  wire logic                                 i_rst,
	input  wire logic [`MH_TAG_W+`MH_INDEX_W-1:0]     i_addr,
	input  wire logic                                 i_acc,
	input  wire mem_hier_pkg::cache_wr_t              i_wr,
	output logic                                      o_hit,
	output logic                                      o_dirty,
	output logic [`MH_TAG_W-1:0]                      o_tag,
	output mem_hier_pkg::line_t                       o_line
);

	localparam int ENTRIES = 1 << `MH_INDEX_W;

	logic [`MH_INDEX_W-1:0] index;
	logic [`MH_TAG_W-1:0]   tag;

	logic [ENTRIES-1:0]     valid_q;
	logic                   dirty_mem [ENTRIES];
	logic [`MH_TAG_W-1:0]   tag_mem   [ENTRIES];
	mem_hier_pkg::line_t    line_mem  [ENTRIES];

	assign index = i_addr[`MH_INDEX_W-1:0];
	assign tag   = i_addr[`MH_TAG_W+`MH_INDEX_W-1:`MH_INDEX_W];

	// Valid bits are the only state cleared by reset.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			valid_q <= '0;
		end else if (i_wr.we) begin
			valid_q[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_wr.we) begin
			tag_mem[index]   <= tag;
			line_mem[index]  <= i_wr.line;
			dirty_mem[index] <= i_wr.dirty;
		end
	end

	// Lookup.
	always_comb begin
		o_hit   = i_acc & valid_q[index] & (tag_mem[index] == tag);
		o_dirty = valid_q[index] & dirty_mem[index]; // Resident line, for eviction.
		o_tag   = tag_mem[index];
		o_line  = line_mem[index];
	end

endmodule

`default_nettype wire

// File: src/mem_hier_pkg.sv
`default_nettype none
`include "mem_hier_params.svh"

package mem_hier_pkg;

	// Word 0 sits in the low bits.
	typedef logic [`MH_LINE_WORDS-1:0][`MH_WORD_W-1:0] line_t;

	// Controller to main memory.
	typedef struct packed {
		logic                              re;
		logic                              we;
		logic [`MH_TAG_W+`MH_INDEX_W-1:0]  addr;  // Line address.
		line_t                             wdata;
	} mem_req_t;

	// Controller to one cache.
	typedef struct packed {
		logic  we;
		logic  dirty; // Stored with the line.
		line_t line;
	} cache_wr_t;

	typedef enum logic [1:0] {
		IDLE,
		D_WRITEBACK,
		D_FILL,
		I_FILL
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: src/mem_hier_params.svh
`ifndef MEM_HIER_PARAMS_SVH
`define MEM_HIER_PARAMS_SVH

// Word and line geometry.
`define MH_WORD_W 16
`define MH_LINE_WORDS 4
`define MH_LINE_W 64

// Address split, tag above index.
`define MH_TAG_W 8
`define MH_INDEX_W 6

`define MH_MEM_LATENCY 4 // Request accepted to ready pulse.

// Output words while in reset.
`define MH_RESET_INSTR 16'hB0FF
`define MH_RESET_DATA 16'h0000

`endif
